// File: Bender.yml
package:
  name: pong

sources:
  # Design
  - files:
      - logic/pongGeomPkg.sv
      - logic/pongGamePkg.sv
      - logic/vgaTiming.sv
      - logic/matchControl.sv
      - logic/paddleMotion.sv
      - logic/ballMotion.sv
      - logic/pixelRenderer.sv
      - logic/pongTop.sv

  # Testbench
  - target: test
    include_dirs:
      - dv
    files:
      - dv/pongTb.sv

// File: dv/pongTests.svh
`ifndef PONG_TESTS_SVH
`define PONG_TESTS_SVH

localparam int MatchTicks  = 3000;
localparam int FrozenTicks = 200;
localparam int HeldTicks   = 5;
localparam int ProbeColumn = 35;
localparam int PaddleResetY = 160;

////////////////////
// Checking helpers
task automatic compareValue(input string name, input logic [31:0] got, input logic [31:0] want);
	assert (got === want)
	else
	begin
		$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
		errCount++;
	end
endtask

task automatic closeTest(input string name, input int startErr);
	if (errCount == startErr)
	begin
		passCount++;
		$display("%-24s ok", name);
	end
	else
	begin
		failCount++;
		$display("%-24s %0d errors", name, errCount - startErr);
	end
endtask

function automatic logic syncLevel(input bit useV);
	return useV ? vsync : hsync;
endfunction

// Switch byte spread over red, green and the top of blue
function automatic logic [8:0] expectColour(input logic [7:0] s, input bit inv);
	logic [7:0] c;
	c = inv ? ~s : s;
	return {c[7:5], c[4:2], c[1:0], 1'b0};
endfunction

function automatic logic [8:0] shownColour();
	return {red, green, blue};
endfunction

// Counts samples until the sync line shows the wanted level
task automatic waitForSync(input bit useV, input logic level, input int limit, output int cycles);
	cycles = 0;
	do
	begin
		@(negedge mclk);
		cycles++;
	end
	while ((syncLevel(useV) !== level) && (cycles <= limit));
	assert (cycles <= limit)
	else
	begin
		$display("%s did not go to %0d within %0d cycles", useV ? "vsync" : "hsync", level, limit);
		errCount++;
	end
endtask

// Falling vsync shows pixel 0 of the first sync line
task automatic lockToFrame;
	int skipped;
	waitForSync(1'b1, 1'b1, FrameCycles, skipped);
	waitForSync(1'b1, 1'b0, FrameCycles, skipped);
	curX = 0;
	curY = int'(VActive + VFront);
endtask

task automatic stepPixel;
	@(negedge mclk);
	curX++;
	if (curX == int'(HTotal))
	begin
		curX = 0;
		curY = (curY + 1) % int'(VTotal);
	end
endtask

////////////////////
// Directed tests
task automatic verifyResetState;
	int startErr;
	startErr = errCount;
	arstN = 1'b0;
	repeat (ResetCycles - 1) @(posedge mclk);
	@(negedge mclk);
	compareValue("hsync", hsync, 1'b1);
	compareValue("vsync", vsync, 1'b1);
	compareValue("colour", shownColour(), '0);
	compareValue("led", led, 8'(1 << LedPlaying));
	@(posedge mclk);
	#DriveDelay;
	arstN = 1'b1;
	closeTest("reset state", startErr);
endtask

task automatic measureSyncTiming;
	int startErr;
	int skipped;
	int lowCycles;
	int highCycles;
	startErr = errCount;
	waitForSync(1'b0, 1'b1, LineCycles, skipped);
	waitForSync(1'b0, 1'b0, LineCycles, skipped);
	waitForSync(1'b0, 1'b1, LineCycles, lowCycles);
	waitForSync(1'b0, 1'b0, LineCycles, highCycles);
	compareValue("hsync low cycles", lowCycles, int'(HSync));
	compareValue("hsync period", lowCycles + highCycles, LineCycles);

	waitForSync(1'b1, 1'b1, FrameCycles, skipped);
	waitForSync(1'b1, 1'b0, FrameCycles, skipped);
	waitForSync(1'b1, 1'b1, FrameCycles, lowCycles);
	waitForSync(1'b1, 1'b0, FrameCycles, highCycles);
	compareValue("vsync low cycles", lowCycles, int'(VSync) * LineCycles);
	compareValue("vsync period", lowCycles + highCycles, FrameCycles);
	closeTest("sync timing", startErr);
endtask

task automatic playToMatchEnd;
	int         startErr;
	int         cycles;
	logic [7:0] prevLed;
	scoreT      oldL;
	scoreT      oldR;
	scoreT      newL;
	scoreT      newR;
	bit         singlePoint;
	startErr = errCount;
	applyReset();
	// Both paddles pushed against the top wall
	btn     = 4'b0101;
	prevLed = led;
	cycles  = 0;
	while (led[LedPlaying] && (cycles < MatchTicks * TickDiv))
	begin
		@(negedge mclk);
		cycles++;
		if (led !== prevLed)
		begin
			oldL = prevLed[LedScoreLeft +: $bits(scoreT)];
			oldR = prevLed[LedScoreRight +: $bits(scoreT)];
			newL = led[LedScoreLeft +: $bits(scoreT)];
			newR = led[LedScoreRight +: $bits(scoreT)];
			singlePoint = ((newL == oldL + 1) && (newR == oldR))
				|| ((newR == oldR + 1) && (newL == oldL));
			assert (singlePoint)
			else
			begin
				$display("FAILED led: 0x%0h after 0x%0h is not a single point", led, prevLed);
				errCount++;
			end
			compareValue("led playing", led[LedPlaying], (newL < WinScore) && (newR < WinScore));
			if (!led[LedPlaying])
				compareValue("led winner", led[LedWinner], newL == WinScore);
			prevLed = led;
		end
	end
	assert (!led[LedPlaying])
	else
	begin
		$display("Match still running after %0d ticks", MatchTicks);
		errCount++;
	end

	// Scoreboard holds still once the match is decided
	cycles = 0;
	while ((cycles < FrozenTicks * TickDiv) && (led === prevLed))
	begin
		@(negedge mclk);
		cycles++;
	end
	compareValue("led after match end", led, prevLed);
	waitCycles(1);
	btn = '0;
	closeTest("scoring and match end", startErr);
endtask

task automatic scanBackground;
	int         startErr;
	logic [8:0] background;
	logic [8:0] inverse;
	logic       expectHsync;
	startErr = errCount;
	waitCycles(1);
	sw         = 8'($urandom);
	background = expectColour(sw, 1'b0);
	inverse    = expectColour(sw, 1'b1);
	lockToFrame();
	// From the start of vsync through line 100
	while (curY != 101)
	begin
		expectHsync = !((curX >= HActive + HFront) && (curX < HActive + HFront + HSync));
		compareValue("hsync", hsync, expectHsync);
		if ((curX >= HActive) || (curY >= VActive))
			compareValue("blank colour", shownColour(), '0);
		if ((curY == 100) && (curX == 200))
			compareValue("background colour", shownColour(), background);
		if ((curY == 100) && (curX == FieldLeft))
			compareValue("wall colour", shownColour(), inverse);
		stepPixel();
	end
	closeTest("blanking and background", startErr);
endtask

task automatic movePaddleUp;
	int         startErr;
	int         spanTop;
	int         spanBottom;
	int         wantTop;
	logic [8:0] inverse;
	startErr = errCount;
	applyReset();
	btn[2] = 1'b1;
	// Half a tick of margin after the last move
	waitCycles(HeldTicks * TickDiv + TickDiv / 2);
	btn        = '0;
	inverse    = expectColour(sw, 1'b1);
	wantTop    = PaddleResetY - HeldTicks * int'(PaddleStep);
	spanTop    = -1;
	spanBottom = -1;
	lockToFrame();
	while (curY != 0)
		stepPixel();
	// Walls excluded, only the paddle remains in this column
	while (curY < VActive)
	begin
		if ((curX == ProbeColumn) && (curY > FieldTop) && (curY < FieldBottom)
			&& (shownColour() === inverse))
		begin
			if (spanTop < 0)
				spanTop = curY;
			spanBottom = curY;
		end
		stepPixel();
	end
	compareValue("paddle top line", spanTop, wantTop);
	compareValue("paddle bottom line", spanBottom, wantTop + int'(PaddleHeight) - 1);
	closeTest("paddle motion", startErr);
endtask

`endif

// File: dv/pongTb.sv
`timescale 1ns/1ps

module pongTb;
	import pongGeomPkg::*;
	import pongGamePkg::*;

	localparam int TickDiv     = 64;
	localparam int WinScore    = 3;
	localparam int ClkPeriod   = 100;
	localparam int DriveDelay  = 10;
	localparam int ResetCycles = 5;
	localparam int Seed        = 57911;

	// Raster lengths in clock cycles
	localparam int LineCycles  = int'(HTotal);
	localparam int FrameCycles = int'(HTotal) * int'(VTotal);

	// Eight frames plus 4000 game ticks
	localparam int WatchdogCycles = 8 * FrameCycles + 4000 * TickDiv;

	logic       mclk;
	logic       arstN;
	logic [7:0] sw;
	logic [3:0] btn;
	logic       hsync;
	logic       vsync;
	logic [2:0] red;
	logic [2:0] green;
	logic [2:0] blue;
	logic [7:0] led;

	int errCount;
	int passCount;
	int failCount;

	// Raster position of the pixel currently on the outputs
	int curX;
	int curY;

	pongTop #(
		.TickDiv  (TickDiv),
		.WinScore (WinScore)
	) u_pongTop (
		.mclk  (mclk),
		.arstN (arstN),
		.sw    (sw),
		.btn   (btn),
		.hsync (hsync),
		.vsync (vsync),
		.red   (red),
		.green (green),
		.blue  (blue),
		.led   (led)
	);

	initial
	begin
		mclk = 1'b0;
		forever #(ClkPeriod / 2) mclk = ~mclk;
	end

	// Leaves the caller just after a rising edge, where inputs change
	task automatic waitCycles(input int n);
		repeat (n) @(posedge mclk);
		#DriveDelay;
	endtask

	task automatic applyReset;
		waitCycles(1);
		arstN = 1'b0;
		waitCycles(ResetCycles);
		arstN = 1'b1;
	endtask

	`include "pongTests.svh"

	////////////////////
	// Watchdog
	initial
	begin
		repeat (WatchdogCycles) @(posedge mclk);
		$display("Watchdog expired after %0d clock cycles", WatchdogCycles);
		$display("tests failed");
		$finish;
	end

	////////////////////
	// Test sequence
	initial
	begin
		arstN     = 1'b0;
		sw        = '0;
		btn       = '0;
		errCount  = 0;
		passCount = 0;
		failCount = 0;
		curX      = 0;
		curY      = 0;
		void'($urandom(Seed));

		verifyResetState();
		measureSyncTiming();
		// Match first, so the ball sits still at the serve spot for the scans
		playToMatchEnd();
		scanBackground();
		movePaddleUp();

		$display("Test count: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+dv
logic/pongGeomPkg.sv
logic/pongGamePkg.sv
logic/vgaTiming.sv
logic/matchControl.sv
logic/paddleMotion.sv
logic/ballMotion.sv
logic/pixelRenderer.sv
logic/pongTop.sv
dv/pongTb.sv

// File: logic/ballMotion.sv
`timescale 1ns/1ps

module ballMotion (
	input  logic               mclk,
	input  logic               arstN,
	input  logic               tick,
	input  logic               playing,
	input  pongGeomPkg::coordT paddleLeftY,
	input  pongGeomPkg::coordT paddleRightY,
	output pongGeomPkg::coordT ballX,
	output pongGeomPkg::coordT ballY,
	output logic               missLeft,
	output logic               missRight
);
	import pongGeomPkg::*;
	import pongGamePkg::*;

	// Turning points of the ball's top left corner
	localparam coordT BallMinX  = FieldLeft + BallStep;
	localparam coordT BallMaxX  = FieldRight - BallSize - BallStep;
	localparam coordT BallMinY  = FieldTop + BallStep;
	localparam coordT BallMaxY  = FieldBottom - BallSize - BallStep;
	localparam coordT LeftHitX  = PaddleLeftX + PaddleWidth;
	localparam coordT RightHitX = PaddleRightX - BallSize;

	logic  dirRight;
	logic  dirDown;
	logic  dirRightNext;
	logic  dirDownNext;
	coordT xNext;
	coordT yNext;
	logic  missL;
	logic  missR;
	logic  atLeftFace;
	logic  atRightFace;
	logic  overlapLeft;
	logic  overlapRight;

	always_comb
	begin
		atLeftFace   = (ballX <= LeftHitX) && (ballX > LeftHitX - BallStep);
		atRightFace  = (ballX >= RightHitX) && (ballX < RightHitX + BallStep);
		overlapLeft  = (ballY + BallSize > paddleLeftY) && (ballY < paddleLeftY + PaddleHeight);
		overlapRight = (ballY + BallSize > paddleRightY) && (ballY < paddleRightY + PaddleHeight);

		xNext        = ballX;
		yNext        = ballY;
		dirRightNext = dirRight;
		dirDownNext  = dirDown;
		missL        = 1'b0;
		missR        = 1'b0;

		// Top and bottom walls
		if (dirDown)
		begin
			if (ballY >= BallMaxY)
			begin
				dirDownNext = 1'b0;
				yNext       = ballY - BallStep;
			end
			else
				yNext = ballY + BallStep;
		end
		else
		begin
			if (ballY <= BallMinY)
			begin
				dirDownNext = 1'b1;
				yNext       = ballY + BallStep;
			end
			else
				yNext = ballY - BallStep;
		end

		// Paddle faces first, then the goal walls
		if (dirRight)
		begin
			if (atRightFace && overlapRight)
			begin
				dirRightNext = 1'b0;
				xNext        = ballX - BallStep;
			end
			else if (ballX >= BallMaxX)
				missR = 1'b1;
			else
				xNext = ballX + BallStep;
		end
		else
		begin
			if (atLeftFace && overlapLeft)
			begin
				dirRightNext = 1'b1;
				xNext        = ballX + BallStep;
			end
			else if (ballX <= BallMinX)
				missL = 1'b1;
			else
				xNext = ballX - BallStep;
		end

		// Serve again, toward the side that just scored
		if (missL || missR)
		begin
			xNext        = BallStartX;
			yNext        = BallStartY;
			dirRightNext = missL;
			dirDownNext  = 1'b1;
		end
	end

	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			ballX     <= BallStartX;
			ballY     <= BallStartY;
			dirRight  <= 1'b1;
			dirDown   <= 1'b1;
			missLeft  <= 1'b0;
			missRight <= 1'b0;
		end
		else
		begin
			missLeft  <= 1'b0;
			missRight <= 1'b0;
			if (tick && playing)
			begin
				ballX     <= xNext;
				ballY     <= yNext;
				dirRight  <= dirRightNext;
				dirDown   <= dirDownNext;
				missLeft  <= missL;
				missRight <= missR;
			end
		end
	end

	ballInField: assert property (
		@(posedge mclk) disable iff (!arstN)
		(ballX >= FieldLeft) && (ballX + BallSize <= FieldRight)
			&& (ballY >= FieldTop) && (ballY + BallSize <= FieldBottom)
	);

endmodule

// File: logic/matchControl.sv
`timescale 1ns/1ps

module matchControl #(
	parameter int TickDiv  = 416667,
	parameter int WinScore = 5
) (
	input  logic               mclk,
	input  logic               arstN,
	input  logic               missLeft,
	input  logic               missRight,
	output logic               tick,
	output logic               playing,
	output pongGamePkg::scoreT scoreLeft,
	output pongGamePkg::scoreT scoreRight,
	output logic               winner
);
	import pongGamePkg::*;

	localparam int    CntW      = (TickDiv > 1) ? $clog2(TickDiv) : 1;
	localparam scoreT LastPoint = scoreT'(WinScore - 1);

	logic [CntW-1:0] tickCnt;
	logic            tickWrap;

	assign tickWrap = (tickCnt == CntW'(TickDiv - 1));

	////////////////////
	// Game tick divider
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			tickCnt <= '0;
			tick    <= 1'b0;
		end
		else
		begin
			tick <= tickWrap && playing;
			if (tickWrap)
				tickCnt <= '0;
			else
				tickCnt <= tickCnt + 1'b1;
		end
	end

	////////////////////
	// Scores and match state
	// A miss by one side is a point for the other
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			scoreLeft  <= '0;
			scoreRight <= '0;
			playing    <= 1'b1;
			winner     <= 1'b0;
		end
		else if (playing)
		begin
			if (missLeft)
			begin
				scoreRight <= scoreRight + 1'b1;
				if (scoreRight == LastPoint)
				begin
					playing <= 1'b0;
					winner  <= 1'b0;
				end
			end
			else if (missRight)
			begin
				scoreLeft <= scoreLeft + 1'b1;
				if (scoreLeft == LastPoint)
				begin
					playing <= 1'b0;
					winner  <= 1'b1;
				end
			end
		end
	end

	scoreLimit: assert property (
		@(posedge mclk) disable iff (!arstN)
		(scoreLeft <= WinScore) && (scoreRight <= WinScore)
	);

	// Ball logic never reports both sides at once
	singleMiss: assert property (
		@(posedge mclk) disable iff (!arstN)
		!(missLeft && missRight)
	);

endmodule

// File: logic/paddleMotion.sv
`timescale 1ns/1ps

module paddleMotion (
	input  logic               mclk,
	input  logic               arstN,
	input  logic               tick,
	input  logic               playing,
	input  logic               up,
	input  logic               down,
	output pongGeomPkg::coordT paddleY
);
	import pongGeomPkg::*;
	import pongGamePkg::*;

	localparam coordT PaddleMinY   = FieldTop;
	localparam coordT PaddleMaxY   = FieldBottom - PaddleHeight;
	// Centred in the field
	localparam coordT PaddleStartY = (FieldTop + FieldBottom - PaddleHeight) / 10'd2;

	// Both buttons or none keep the paddle where it is
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
			paddleY <= PaddleStartY;
		else if (tick && playing)
		begin
			if (up && !down)
			begin
				if (paddleY < PaddleMinY + PaddleStep)
					paddleY <= PaddleMinY;
				else
					paddleY <= paddleY - PaddleStep;
			end
			else if (down && !up)
			begin
				if (paddleY > PaddleMaxY - PaddleStep)
					paddleY <= PaddleMaxY;
				else
					paddleY <= paddleY + PaddleStep;
			end
		end
	end

	paddleInField: assert property (
		@(posedge mclk) disable iff (!arstN)
		(paddleY >= PaddleMinY) && (paddleY <= PaddleMaxY)
	);

endmodule

// File: logic/pixelRenderer.sv
`timescale 1ns/1ps

module pixelRenderer (
	input  logic               mclk,
	input  logic               arstN,
	input  pongGeomPkg::coordT hPos,
	input  pongGeomPkg::coordT vPos,
	input  logic               active,
	input  logic               hsyncRaw,
	input  logic               vsyncRaw,
	input  pongGeomPkg::coordT paddleLeftY,
	input  pongGeomPkg::coordT paddleRightY,
	input  pongGeomPkg::coordT ballX,
	input  pongGeomPkg::coordT ballY,
	input  logic [7:0]         colourSel,
	output logic [2:0]         red,
	output logic [2:0]         green,
	output logic [2:0]         blue,
	output logic               hsync,
	output logic               vsync
);
	import pongGeomPkg::*;

	localparam coordT FieldWidth  = FieldRight - FieldLeft + 10'd1;
	localparam coordT FieldHeight = FieldBottom - FieldTop + 10'd1;

	logic wallHit;
	logic paddleHit;
	logic ballHit;
	logic painted;

	// Point inside a rectangle given by corner and size
	function automatic logic inRect(
		input coordT x,
		input coordT y,
		input coordT left,
		input coordT top,
		input coordT width,
		input coordT height
	);
		return (x >= left) && (x < left + width) && (y >= top) && (y < top + height);
	endfunction

	////////////////////
	// Hit tests
	assign wallHit =
		inRect(hPos, vPos, FieldLeft, FieldTop, 10'd1, FieldHeight) ||
		inRect(hPos, vPos, FieldRight, FieldTop, 10'd1, FieldHeight) ||
		inRect(hPos, vPos, FieldLeft, FieldTop, FieldWidth, 10'd1) ||
		inRect(hPos, vPos, FieldLeft, FieldBottom, FieldWidth, 10'd1);

	assign paddleHit =
		inRect(hPos, vPos, PaddleLeftX, paddleLeftY, PaddleWidth, PaddleHeight) ||
		inRect(hPos, vPos, PaddleRightX, paddleRightY, PaddleWidth, PaddleHeight);

	assign ballHit = inRect(hPos, vPos, ballX, ballY, BallSize, BallSize);

	assign painted = wallHit || paddleHit || ballHit;

	////////////////////
	// Output stage, colour and sync share one register
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else
		begin
			hsync <= hsyncRaw;
			vsync <= vsyncRaw;
			if (!active)
			begin
				red   <= '0;
				green <= '0;
				blue  <= '0;
			end
			else if (painted)
			begin
				// Objects in the inverse of the background
				red   <= ~colourSel[7:5];
				green <= ~colourSel[4:2];
				blue  <= {~colourSel[1:0], 1'b0};
			end
			else
			begin
				red   <= colourSel[7:5];
				green <= colourSel[4:2];
				blue  <= {colourSel[1:0], 1'b0};
			end
		end
	end

endmodule

// File: logic/pongGamePkg.sv
package pongGamePkg;

	// Points of one player
	typedef logic [2:0] scoreT;

	////////////////////
	// Motion per game tick, in pixels
	localparam logic [3:0] PaddleStep = 4'd4;

	// Applied to x and y alike
	localparam logic [3:0] BallStep = 4'd2;

	////////////////////
	// LED bit layout
	// Score fields are given by their lowest bit
	localparam int LedScoreLeft  = 0;
	localparam int LedScoreRight = 3;
	localparam int LedPlaying    = 6;

	// Set when the left player won
	localparam int LedWinner = 7;

endpackage

// File: logic/pongGeomPkg.sv
package pongGeomPkg;

	// Pixel or line coordinate on the raster
	typedef logic [9:0] coordT;

	////////////////////
	// Horizontal raster timing, in pixels
	localparam coordT HActive = 10'd640;
	localparam coordT HFront  = 10'd16;
	localparam coordT HSync   = 10'd96;
	localparam coordT HBack   = 10'd48;
	localparam coordT HTotal  = 10'd800;

	// Vertical raster timing, in lines
	localparam coordT VActive = 10'd480;
	localparam coordT VFront  = 10'd10;
	localparam coordT VSync   = 10'd2;
	localparam coordT VBack   = 10'd33;
	localparam coordT VTotal  = 10'd525;

	////////////////////
	// Playing field walls
	localparam coordT FieldLeft   = 10'd10;
	localparam coordT FieldRight  = 10'd630;
	localparam coordT FieldTop    = 10'd10;
	localparam coordT FieldBottom = 10'd370;

	// Paddles and ball
	localparam coordT PaddleWidth  = 10'd10;
	localparam coordT PaddleHeight = 10'd60;
	localparam coordT PaddleLeftX  = 10'd30;
	localparam coordT PaddleRightX = 10'd600;
	localparam coordT BallSize     = 10'd8;
	localparam coordT BallStartX   = 10'd316;
	localparam coordT BallStartY   = 10'd186;

endpackage

// File: logic/pongTop.sv
`timescale 1ns/1ps

module pongTop #(
	parameter int TickDiv  = 416667,
	parameter int WinScore = 5
) (
	input  logic       mclk,
	input  logic       arstN,
	input  logic [7:0] sw,
	input  logic [3:0] btn,
	output logic       hsync,
	output logic       vsync,
	output logic [2:0] red,
	output logic [2:0] green,
	output logic [2:0] blue,
	output logic [7:0] led
);
	import pongGeomPkg::*;
	import pongGamePkg::*;

	// Raster
	coordT hPos;
	coordT vPos;
	logic  active;
	logic  hsyncRaw;
	logic  vsyncRaw;

	// Game state
	logic  tick;
	logic  playing;
	logic  winner;
	scoreT scoreLeft;
	scoreT scoreRight;
	logic  missLeft;
	logic  missRight;
	coordT paddleLeftY;
	coordT paddleRightY;
	coordT ballX;
	coordT ballY;

	vgaTiming u_vgaTiming (
		.mclk     (mclk),
		.arstN    (arstN),
		.hPos     (hPos),
		.vPos     (vPos),
		.active   (active),
		.hsyncRaw (hsyncRaw),
		.vsyncRaw (vsyncRaw)
	);

	matchControl #(
		.TickDiv  (TickDiv),
		.WinScore (WinScore)
	) u_matchControl (
		.mclk       (mclk),
		.arstN      (arstN),
		.missLeft   (missLeft),
		.missRight  (missRight),
		.tick       (tick),
		.playing    (playing),
		.scoreLeft  (scoreLeft),
		.scoreRight (scoreRight),
		.winner     (winner)
	);

	// Left player on buttons 2 and 3
	paddleMotion u_paddleLeft (
		.mclk    (mclk),
		.arstN   (arstN),
		.tick    (tick),
		.playing (playing),
		.up      (btn[2]),
		.down    (btn[3]),
		.paddleY (paddleLeftY)
	);

	paddleMotion u_paddleRight (
		.mclk    (mclk),
		.arstN   (arstN),
		.tick    (tick),
		.playing (playing),
		.up      (btn[0]),
		.down    (btn[1]),
		.paddleY (paddleRightY)
	);

	ballMotion u_ballMotion (
		.mclk         (mclk),
		.arstN        (arstN),
		.tick         (tick),
		.playing      (playing),
		.paddleLeftY  (paddleLeftY),
		.paddleRightY (paddleRightY),
		.ballX        (ballX),
		.ballY        (ballY),
		.missLeft     (missLeft),
		.missRight    (missRight)
	);

	pixelRenderer u_pixelRenderer (
		.mclk         (mclk),
		.arstN        (arstN),
		.hPos         (hPos),
		.vPos         (vPos),
		.active       (active),
		.hsyncRaw     (hsyncRaw),
		.vsyncRaw     (vsyncRaw),
		.paddleLeftY  (paddleLeftY),
		.paddleRightY (paddleRightY),
		.ballX        (ballX),
		.ballY        (ballY),
		.colourSel    (sw),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.hsync        (hsync),
		.vsync        (vsync)
	);

	// Scoreboard LEDs
	always_comb
	begin
		led = '0;
		led[LedScoreLeft +: $bits(scoreT)]  = scoreLeft;
		led[LedScoreRight +: $bits(scoreT)] = scoreRight;
		led[LedPlaying]                     = playing;
		led[LedWinner]                      = winner;
	end

endmodule

// File: logic/vgaTiming.sv
`timescale 1ns/1ps

module vgaTiming (
	input  logic               mclk,
	input  logic               arstN,
	output pongGeomPkg::coordT hPos,
	output pongGeomPkg::coordT vPos,
	output logic               active,
	output logic               hsyncRaw,
	output logic               vsyncRaw
);
	import pongGeomPkg::*;

	// Sync pulse windows
	localparam coordT HSyncStart = HActive + HFront;
	localparam coordT HSyncEnd   = HSyncStart + HSync;
	localparam coordT VSyncStart = VActive + VFront;
	localparam coordT VSyncEnd   = VSyncStart + VSync;

	coordT hNext;
	coordT vNext;
	logic  lineEnd;

	// Position of the next pixel
	always_comb
	begin
		lineEnd = (hPos == HTotal - 10'd1);
		hNext   = lineEnd ? '0 : hPos + 10'd1;
		vNext   = vPos;
		if (lineEnd)
		begin
			vNext = (vPos == VTotal - 10'd1) ? '0 : vPos + 10'd1;
		end
	end

	// Flags are derived from the next position so they
	// line up with the registered coordinates
	always_ff @(posedge mclk or negedge arstN)
	begin
		if (!arstN)
		begin
			hPos     <= '0;
			vPos     <= '0;
			active   <= 1'b1;
			hsyncRaw <= 1'b1;
			vsyncRaw <= 1'b1;
		end
		else
		begin
			hPos     <= hNext;
			vPos     <= vNext;
			active   <= (hNext < HActive) && (vNext < VActive);
			hsyncRaw <= !((hNext >= HSyncStart) && (hNext < HSyncEnd));
			vsyncRaw <= !((vNext >= VSyncStart) && (vNext < VSyncEnd));
		end
	end

	// Counters never leave the raster
	posInRaster: assert property (
		@(posedge mclk) disable iff (!arstN)
		(hPos < HTotal) && (vPos < VTotal)
	);

endmodule
